/* include/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width of the RV32 core
`define RV_XLEN 32

// architectural register file
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// program counter
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 32'd4

// shift amounts use the low bits of the second operand
`define RV_SHAMT_W 5

`endif

/* rtl/rv_alu.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e op,
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  output rv_isa_pkg::word_t    result
);

  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   lt_signed;
  logic                   lt_unsigned;

  assign shamt       = b[`RV_SHAMT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_core_pkg::ADD:    result = a + b;
      rv_core_pkg::SUB:    result = a - b;
      rv_core_pkg::SLL:    result = a << shamt;
      // set-less-than gives 0 or 1 in bit 0
      rv_core_pkg::SLT:    result = rv_isa_pkg::word_t'(lt_signed);
      rv_core_pkg::SLTU:   result = rv_isa_pkg::word_t'(lt_unsigned);
      rv_core_pkg::XOR:    result = a ^ b;
      rv_core_pkg::SRL:    result = a >> shamt;
      rv_core_pkg::SRA:    result = rv_isa_pkg::word_t'($signed(a) >>> shamt);
      rv_core_pkg::OR:     result = a | b;
      rv_core_pkg::AND:    result = a & b;
      // lui, the immediate goes straight through
      rv_core_pkg::PASS_B: result = b;
      default:             result = '0;
    endcase
  end

endmodule

/* rtl/rv_control_fsm.sv */
`timescale 1ns/1ns

module rv_control_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     is_ecall,
  output rv_core_pkg::ctrl_state_e state
);

  rv_core_pkg::ctrl_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      // imem word for the current pc arrives at the end of this cycle
      rv_core_pkg::ST_FETCH: state_next = rv_core_pkg::ST_EXECUTE;
      rv_core_pkg::ST_EXECUTE: begin
        if (is_ecall) begin
          state_next = rv_core_pkg::ST_HALTED;
        end else begin
          state_next = rv_core_pkg::ST_FETCH;
        end
      end
      // only reset leaves halted
      rv_core_pkg::ST_HALTED: state_next = rv_core_pkg::ST_HALTED;
      default: state_next = rv_core_pkg::ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_core_pkg::ST_FETCH;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::word_t    insn,
  output rv_isa_pkg::word_t    pc,
  output logic                 halt,
  output rv_core_pkg::retire_t retire,
  output rv_isa_pkg::word_t    cycle_count,
  output rv_isa_pkg::word_t    insn_count
);

  rv_core_pkg::ctrl_state_e state;
  rv_core_pkg::decoded_t    dec;
  rv_isa_pkg::word_t        rs1_data;
  rv_isa_pkg::word_t        rs2_data;
  rv_isa_pkg::word_t        alu_b;
  rv_isa_pkg::word_t        alu_result;
  rv_isa_pkg::word_t        wb_data;
  logic                     execute;
  logic                     we;

  assign execute = (state == rv_core_pkg::ST_EXECUTE);
  assign halt    = (state == rv_core_pkg::ST_HALTED);

  rv_control_fsm ctrl_i (.clk(clk), .rst(rst), .is_ecall(dec.is_ecall), .state(state));

  rv_decoder dec_i (.insn(insn), .dec(dec));

  // jal links the return address, everything else writes the alu result
  assign wb_data = dec.is_jal ? pc + `RV_PC_STEP : alu_result;
  assign we      = execute && dec.reg_write;

  rv_reg_file rf_i (
    .clk(clk), .rst(rst), .we(we), .rd(dec.rd), .rs1(dec.rs1), .rs2(dec.rs2),
    .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu alu_i (.op(dec.alu_op), .a(rs1_data), .b(alu_b), .result(alu_result));

  rv_pc_unit pc_i (
    .clk(clk), .rst(rst), .execute(execute), .dec(dec),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc)
  );

  rv_perf_counters perf_i (
    .clk(clk), .rst(rst), .execute(execute), .halt(halt),
    .cycle_count(cycle_count), .insn_count(insn_count)
  );

  // retire report for the instruction in execute
  assign retire.valid     = execute;
  assign retire.pc        = pc;
  assign retire.reg_write = we;
  assign retire.rd        = dec.rd;
  assign retire.rd_data   = wb_data;

endmodule

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

  // operations of the ALU
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // instruction after decode
  typedef struct packed {
    rv_isa_pkg::reg_idx_t   rs1;
    rv_isa_pkg::reg_idx_t   rs2;
    rv_isa_pkg::reg_idx_t   rd;
    rv_isa_pkg::word_t      imm;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   reg_write;
    logic                   is_branch;
    rv_isa_pkg::branch_f3_e branch_cond;
    logic                   is_jal;
    logic                   is_ecall;
  } decoded_t;

  // what the core reports for each retired instruction
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::word_t    pc;
    logic                 reg_write;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    rd_data;
  } retire_t;

  // two cycles per instruction, halted after ECALL
  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_EXECUTE = 2'd1,
    ST_HALTED  = 2'd2
  } ctrl_state_e;

endpackage

/* rtl/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder (
  input  rv_isa_pkg::word_t     insn,
  output rv_core_pkg::decoded_t dec
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_b;
  rv_isa_pkg::word_t imm_j;
  rv_isa_pkg::word_t imm_u;
  logic              alt;
  logic              funct7_ok;

  // OP and OP-IMM share the funct3 mapping, alt selects SUB or SRA
  function automatic rv_core_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt_sel);
    rv_core_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: op = alt_sel ? rv_core_pkg::SUB : rv_core_pkg::ADD;
      rv_isa_pkg::F3_SLL:     op = rv_core_pkg::SLL;
      rv_isa_pkg::F3_SLT:     op = rv_core_pkg::SLT;
      rv_isa_pkg::F3_SLTU:    op = rv_core_pkg::SLTU;
      rv_isa_pkg::F3_XOR:     op = rv_core_pkg::XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt_sel ? rv_core_pkg::SRA : rv_core_pkg::SRL;
      rv_isa_pkg::F3_OR:      op = rv_core_pkg::OR;
      default:                op = rv_core_pkg::AND;
    endcase
    return op;
  endfunction

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign alt    = (funct7 == rv_isa_pkg::FUNCT7_ALT);

  // immediates, scrambled per the base ISA formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // funct7 must be zero, or ALT on the two funct3 values that have an alternate
  assign funct7_ok = (funct7 == 7'd0) ||
                     (alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                              funct3 == rv_isa_pkg::F3_SRL_SRA));

  always_comb begin
    dec = '0;
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    dec.alu_op = rv_core_pkg::ADD;
    dec.branch_cond = rv_isa_pkg::BEQ;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        dec.imm = imm_u;
        dec.alu_op = rv_core_pkg::PASS_B;
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        // addi has no alternate, its bit 30 belongs to the immediate
        dec.alu_op = f3_to_op(funct3, alt && funct3 == rv_isa_pkg::F3_SRL_SRA);
        if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          dec.reg_write = funct7_ok;
        end else begin
          dec.reg_write = 1'b1;
        end
      end
      rv_isa_pkg::OP_REG: begin
        dec.alu_op = f3_to_op(funct3, alt);
        dec.reg_write = funct7_ok;
      end
      rv_isa_pkg::OP_BRANCH: begin
        dec.imm = imm_b;
        dec.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
        dec.branch_cond = rv_isa_pkg::branch_f3_e'(funct3);
      end
      rv_isa_pkg::OP_JAL: begin
        dec.imm = imm_j;
        dec.is_jal = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_SYSTEM: dec.is_ecall = (insn[31:7] == 25'd0);
      default: dec.reg_write = 1'b0;
    endcase
  end

endmodule

/* rtl/rv_isa_pkg.sv */
`include "rv_consts.svh"

package rv_isa_pkg;

  // one data or address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register number
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // major opcodes of the kept instruction groups
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the conditional branches, 010 and 011 are unused
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } alu_f3_e;

  // funct7 that turns ADD into SUB and SRL into SRA
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

/* rtl/rv_pc_unit.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_pc_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  execute,
  input  rv_core_pkg::decoded_t dec,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  output rv_isa_pkg::word_t     pc
);

  logic equal;
  logic lt_signed;
  logic lt_unsigned;
  logic cond;
  logic taken;

  assign equal       = (rs1_data == rs2_data);
  assign lt_signed   = $signed(rs1_data) < $signed(rs2_data);
  assign lt_unsigned = rs1_data < rs2_data;

  always_comb begin
    case (dec.branch_cond)
      rv_isa_pkg::BEQ:  cond = equal;
      rv_isa_pkg::BNE:  cond = !equal;
      rv_isa_pkg::BLT:  cond = lt_signed;
      rv_isa_pkg::BGE:  cond = !lt_signed;
      rv_isa_pkg::BLTU: cond = lt_unsigned;
      rv_isa_pkg::BGEU: cond = !lt_unsigned;
      default:          cond = 1'b0;
    endcase
  end

  assign taken = (dec.is_branch && cond) || dec.is_jal;

  // pc only moves at the end of the execute cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (execute) begin
      pc <= taken ? pc + dec.imm : pc + `RV_PC_STEP;
    end
  end

endmodule

/* rtl/rv_perf_counters.sv */
`timescale 1ns/1ns

module rv_perf_counters (
  input  logic              clk,
  input  logic              rst,
  input  logic              execute,
  input  logic              halt,
  output rv_isa_pkg::word_t cycle_count,
  output rv_isa_pkg::word_t insn_count
);

  // counts every running cycle of fetch and execute
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_count <= '0;
    end else if (!halt) begin
      cycle_count <= cycle_count + rv_isa_pkg::word_t'(1);
    end
  end

  // one per retired instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      insn_count <= '0;
    end else if (execute) begin
      insn_count <= insn_count + rv_isa_pkg::word_t'(1);
    end
  end

endmodule

/* rtl/rv_reg_file.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::word_t    rd_data,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  rv_isa_pkg::word_t regs [`RV_REG_COUNT];

  // x0 is hardwired, whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --top-module tb_rv_core -f sources.f -Mdir obj_dir \
  && { ./obj_dir/Vtb_rv_core > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q "TESTS FAILED" sim.log \
  || { echo "simulation failed"; exit 1; }

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module tb_rv_core;

  localparam int NUM_PROGS   = 40;
  localparam int PROG_WORDS  = 48;
  localparam int CLK_PERIOD  = 10;
  localparam int WATCHDOG_NS = NUM_PROGS * (2 * PROG_WORDS + 10) * CLK_PERIOD;

  logic                 clk;
  logic                 rst;
  rv_isa_pkg::word_t    insn;
  rv_isa_pkg::word_t    pc;
  logic                 halt;
  rv_core_pkg::retire_t retire;
  rv_isa_pkg::word_t    cycle_count;
  rv_isa_pkg::word_t    insn_count;

  integer               seed = 32'hbcec;
  int                   error_count = 0;
  int                   read_idx = 0;
  rv_isa_pkg::word_t    imem [PROG_WORDS];
  rv_isa_pkg::word_t    model_regs [`RV_REG_COUNT];

  tb_clock #(.PERIOD(CLK_PERIOD)) clock_i (.clk(clk));

  rv_core rv_core_i (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc), .halt(halt),
    .retire(retire), .cycle_count(cycle_count), .insn_count(insn_count)
  );

  // instruction memory with a one-cycle read of the pc sampled before the edge
  always @(negedge clk) begin
    read_idx = int'(pc >> 2);
  end

  always @(posedge clk) begin
    #1;
    insn = (read_idx < PROG_WORDS) ? imem[read_idx] : '0;
  end

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // one random instruction for slot idx
  // jumps only go forward inside the program
  function automatic rv_isa_pkg::word_t random_insn(input int idx);
    int                   kind;
    int                   span;
    int                   sel;
    logic                 alt;
    logic [2:0]           f3;
    logic [11:0]          imm12;
    logic [12:0]          boff;
    logic [20:0]          joff;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    kind  = pick(20);
    rd    = rv_isa_pkg::reg_idx_t'(pick(8));
    rs1   = rv_isa_pkg::reg_idx_t'(pick(8));
    rs2   = rv_isa_pkg::reg_idx_t'(pick(8));
    f3    = 3'(pick(8));
    alt   = (pick(2) == 1);
    imm12 = 12'($random(seed));
    span  = 1 + pick((PROG_WORDS - 1 - idx < 6) ? PROG_WORDS - 1 - idx : 6);
    case (kind)
      0, 1, 2: return {20'($random(seed)), rd, rv_isa_pkg::OP_LUI};
      3, 4, 5, 6, 7, 8: begin
        // shift immediates carry funct7 in their upper bits
        if (f3 == 3'd1) begin
          imm12 = {7'd0, imm12[4:0]};
        end else if (f3 == 3'd5) begin
          imm12 = {alt ? rv_isa_pkg::FUNCT7_ALT : 7'd0, imm12[4:0]};
        end
        return {imm12, rs1, f3, rd, rv_isa_pkg::OP_IMM};
      end
      9, 10, 11, 12, 13: begin
        alt = alt && (f3 == 3'd0 || f3 == 3'd5);
        return {alt ? rv_isa_pkg::FUNCT7_ALT : 7'd0, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
      end
      14, 15, 16: begin
        sel  = pick(6);
        f3   = 3'((sel < 2) ? sel : sel + 2);
        boff = 13'(span * 4);
        if (pick(4) == 0) begin
          rs2 = rs1;
        end
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], rv_isa_pkg::OP_BRANCH};
      end
      17: begin
        joff = 21'(span * 4);
        return {joff[20], joff[10:1], joff[11], joff[19:12], rd, rv_isa_pkg::OP_JAL};
      end
      // load opcode and M extension are not part of this core
      18: return {25'($random(seed)), 7'b0000011};
      default: return {7'b0000001, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
    endcase
  endfunction

  // RV32I arithmetic for OP and OP-IMM
  function automatic rv_isa_pkg::word_t arith(input logic [2:0] f3, input logic alt,
                                              input rv_isa_pkg::word_t a,
                                              input rv_isa_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[`RV_SHAMT_W-1:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[`RV_SHAMT_W-1:0])
                       : a >> b[`RV_SHAMT_W-1:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes the instruction at cur_pc on the model registers
  task automatic model_step(input rv_isa_pkg::word_t cur_pc, output rv_core_pkg::retire_t exp,
                            output rv_isa_pkg::word_t next_pc, output logic stop);
    rv_isa_pkg::word_t w;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              taken;
    w       = imem[int'(cur_pc >> 2)];
    f3      = w[14:12];
    f7      = w[31:25];
    a       = model_regs[w[19:15]];
    b       = model_regs[w[24:20]];
    exp     = '0;
    exp.valid = 1'b1;
    exp.pc  = cur_pc;
    exp.rd  = w[11:7];
    next_pc = cur_pc + `RV_PC_STEP;
    stop    = 1'b0;
    taken   = 1'b0;
    case (w[6:0])
      rv_isa_pkg::OP_LUI: begin
        exp.reg_write = 1'b1;
        exp.rd_data   = {w[31:12], 12'd0};
      end
      rv_isa_pkg::OP_IMM: begin
        if (f3 == 3'd1) begin
          exp.reg_write = (f7 == 7'd0);
        end else if (f3 == 3'd5) begin
          exp.reg_write = (f7 == 7'd0 || f7 == rv_isa_pkg::FUNCT7_ALT);
        end else begin
          exp.reg_write = 1'b1;
        end
        exp.rd_data = arith(f3, f3 == 3'd5 && f7[5], a, {{20{w[31]}}, w[31:20]});
      end
      rv_isa_pkg::OP_REG: begin
        exp.reg_write = (f7 == 7'd0) ||
                        (f7 == rv_isa_pkg::FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        exp.rd_data   = arith(f3, f7[5], a, b);
      end
      rv_isa_pkg::OP_BRANCH: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          3'd7: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = cur_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      rv_isa_pkg::OP_JAL: begin
        exp.reg_write = 1'b1;
        exp.rd_data   = cur_pc + `RV_PC_STEP;
        next_pc       = cur_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: stop = (w == {25'd0, rv_isa_pkg::OP_SYSTEM});
    endcase
    if (exp.reg_write && exp.rd != '0) begin
      model_regs[exp.rd] = exp.rd_data;
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input rv_isa_pkg::word_t actual, input rv_isa_pkg::word_t expected,
                            input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    end
  endtask

  task automatic check_state(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
    end
  endtask

  task automatic check_retire(input rv_core_pkg::retire_t actual,
                              input rv_core_pkg::retire_t expected);
    logic ok;
    ok = actual.valid === expected.valid && actual.pc === expected.pc &&
         actual.reg_write === expected.reg_write;
    // rd and rd_data carry meaning only with a register write
    if (expected.reg_write) begin
      ok = ok && actual.rd === expected.rd && actual.rd_data === expected.rd_data;
    end
    if (!ok) begin
      report_failure({$sformatf("MISMATCH at %0t: retire pc %h we %b rd %0d data %h",
                                $time, actual.pc, actual.reg_write, actual.rd,
                                actual.rd_data),
                      $sformatf(", expected pc %h we %b rd %0d data %h",
                                expected.pc, expected.reg_write, expected.rd,
                                expected.rd_data)});
    end
  endtask

  task automatic expect_running(input int cycles, input int retired);
    check_state(halt, 1'b0, "halt while running");
    check_word(cycle_count, rv_isa_pkg::word_t'(cycles), "cycle_count");
    check_word(insn_count, rv_isa_pkg::word_t'(retired), "insn_count");
  endtask

  task automatic run_program();
    rv_isa_pkg::word_t    model_pc;
    rv_isa_pkg::word_t    next_pc;
    rv_core_pkg::retire_t exp;
    logic                 stop;
    int                   cycles;
    int                   retired;
    @(posedge clk);
    #1 rst = 1'b1;
    @(negedge clk);
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      imem[i] = random_insn(i);
    end
    imem[PROG_WORDS - 1] = {25'd0, rv_isa_pkg::OP_SYSTEM};
    for (int i = 0; i < `RV_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    model_pc = `RV_RESET_PC;
    cycles   = 0;
    retired  = 0;
    stop     = 1'b0;
    // lockstep with the model over one fetch and one execute cycle per instruction
    while (!stop) begin
      @(negedge clk);
      check_word(pc, model_pc, "pc in fetch");
      check_state(retire.valid, 1'b0, "retire valid in fetch");
      expect_running(cycles, retired);
      cycles++;
      @(negedge clk);
      model_step(model_pc, exp, next_pc, stop);
      check_retire(retire, exp);
      expect_running(cycles, retired);
      cycles++;
      retired++;
      model_pc = next_pc;
    end
    repeat (3) begin
      @(negedge clk);
      check_state(halt, 1'b1, "halt after ecall");
      check_state(retire.valid, 1'b0, "retire valid while halted");
      check_word(pc, model_pc, "pc while halted");
      check_word(insn_count, rv_isa_pkg::word_t'(retired), "insn_count at halt");
      check_word(cycle_count, rv_isa_pkg::word_t'(2 * retired), "cycle_count at halt");
    end
  endtask

  initial begin
    rst  = 1'b1;
    insn = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program();
    end
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout: the programs did not finish within the expected time");
  end

endmodule

/* sources.f */
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_control_fsm.sv
rtl/rv_perf_counters.sv
rtl/rv_decoder.sv
rtl/rv_reg_file.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv
